/* logic/tile_pkg.sv */
package tile_pkg;

  // Core bus masters, 0 is instruction and 1 is data
  localparam int NR_MASTERS = 2;

  // Address map over the top address bits
  localparam int         DM_RANGE_WIDTH   = 4;
  localparam logic [3:0] DM_MATCH         = 4'h0;
  localparam int         BOOT_RANGE_WIDTH = 4;
  localparam logic [3:0] BOOT_MATCH       = 4'hf;

  // Local memory in bytes, addressed by word
  localparam int LMEM_SIZE = 4096;
  localparam int LMEM_AW   = 10;

  localparam int BOOT_WORDS = 16;

  // Startup code, entry n sits at byte address 4*n of the boot range
  localparam logic [31:0] BOOT_IMAGE [0:BOOT_WORDS-1] = '{
    32'h18000000, 32'ha8200000, 32'h18400000, 32'ha8420ffc,
    32'h18600000, 32'ha8630100, 32'h44001800, 32'h15000000,
    32'h9c21fff8, 32'hd4011000, 32'h84410000, 32'h9c210008,
    32'he0630004, 32'hbc030000, 32'h0ffffff8, 32'h15000001
  };

  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

endpackage

/* logic/tile_bus_arbiter.sv */
`timescale 1ns/1ns

module tile_bus_arbiter (
  input  logic                                         clk,
  input  logic                                         rst_i,
  input  tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] m_req_i,
  output tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] m_rsp_o,
  output tile_pkg::wb_req_t                            bus_req_o,
  input  tile_pkg::wb_rsp_t                            bus_rsp_i
);

  logic                            owned_q;
  logic                            grant_q;
  logic                            last_q;
  logic                            next_grant;
  logic                            bus_done;
  logic [tile_pkg::NR_MASTERS-1:0] cyc_vec;
  logic [tile_pkg::NR_MASTERS-1:0] sel;
  logic [tile_pkg::NR_MASTERS-1:0] rsp_hit;

  for (genvar i = 0; i < tile_pkg::NR_MASTERS; i++) begin : gen_master
    assign cyc_vec[i]     = m_req_i[i].cyc;
    assign sel[i]         = owned_q && (grant_q == 1'(i));
    assign m_rsp_o[i].dat = bus_rsp_i.dat;
    assign m_rsp_o[i].ack = bus_rsp_i.ack & sel[i];
    assign m_rsp_o[i].err = bus_rsp_i.err & sel[i];
    assign rsp_hit[i]     = m_rsp_o[i].ack | m_rsp_o[i].err;
  end

  // On a tie the master that did not own the bus last goes first
  assign next_grant = (cyc_vec[0] && cyc_vec[1]) ? ~last_q : cyc_vec[1];
  assign bus_done   = bus_rsp_i.ack | bus_rsp_i.err;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      owned_q <= 1'b0;
      grant_q <= 1'b0;
      last_q  <= 1'b1;
    end else if (!owned_q) begin
      if (|cyc_vec) begin
        owned_q <= 1'b1;
        grant_q <= next_grant;
      end
    end else if (bus_done || !m_req_i[grant_q].cyc) begin
      owned_q <= 1'b0;
      last_q  <= grant_q;
    end
  end

  assign bus_req_o = owned_q ? m_req_i[grant_q] : '0;

  a_single_rsp: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(rsp_hit))
    else $error("response routed to more than one master");

endmodule

/* logic/tile_addr_decoder.sv */
`timescale 1ns/1ns

module tile_addr_decoder (
  input  logic              clk,
  input  logic              rst_i,
  input  tile_pkg::wb_req_t bus_req_i,
  output tile_pkg::wb_rsp_t bus_rsp_o,
  output tile_pkg::wb_req_t dm_req_o,
  input  tile_pkg::wb_rsp_t dm_rsp_i,
  output tile_pkg::wb_req_t boot_req_o,
  input  tile_pkg::wb_rsp_t boot_rsp_i
);

  logic dm_hit;
  logic boot_hit;
  logic err_q;

  assign dm_hit   = bus_req_i.adr[31 -: tile_pkg::DM_RANGE_WIDTH] == tile_pkg::DM_MATCH;
  assign boot_hit = bus_req_i.adr[31 -: tile_pkg::BOOT_RANGE_WIDTH] == tile_pkg::BOOT_MATCH;

  always_comb begin
    dm_req_o       = bus_req_i;
    dm_req_o.cyc   = bus_req_i.cyc & dm_hit;
    dm_req_o.stb   = bus_req_i.stb & dm_hit;
    boot_req_o     = bus_req_i;
    boot_req_o.cyc = bus_req_i.cyc & boot_hit;
    boot_req_o.stb = bus_req_i.stb & boot_hit;
  end

  // Unmapped address, one err pulse while the master still holds the request
  always_ff @(posedge clk) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_req_i.cyc & bus_req_i.stb & !dm_hit & !boot_hit & !err_q;
    end
  end

  always_comb begin
    bus_rsp_o.dat = boot_hit ? boot_rsp_i.dat : dm_rsp_i.dat;
    bus_rsp_o.ack = dm_rsp_i.ack | boot_rsp_i.ack;
    bus_rsp_o.err = dm_rsp_i.err | boot_rsp_i.err | err_q;
  end

  a_one_slave: assert property (@(posedge clk) disable iff (rst_i)
    !(dm_req_o.stb && boot_req_o.stb))
    else $error("both slaves strobed");

endmodule

/* logic/mem_port_mux.sv */
`timescale 1ns/1ns

module mem_port_mux (
  input  logic              clk,
  input  logic              rst_i,
  input  tile_pkg::wb_req_t bus_req_i,
  output tile_pkg::wb_rsp_t bus_rsp_o,
  input  tile_pkg::wb_req_t dbg_req_i,
  output tile_pkg::wb_rsp_t dbg_rsp_o,
  output tile_pkg::wb_req_t mem_req_o,
  input  tile_pkg::wb_rsp_t mem_rsp_i
);

  logic busy_q;
  logic dbg_own_q;
  logic owner_cyc;
  logic mem_done;

  assign owner_cyc = dbg_own_q ? dbg_req_i.cyc : bus_req_i.cyc;
  assign mem_done  = mem_rsp_i.ack | mem_rsp_i.err;

  // Debug access takes precedence when the memory is free
  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      dbg_own_q <= 1'b0;
    end else if (!busy_q) begin
      if (dbg_req_i.cyc) begin
        busy_q    <= 1'b1;
        dbg_own_q <= 1'b1;
      end else if (bus_req_i.cyc) begin
        busy_q    <= 1'b1;
        dbg_own_q <= 1'b0;
      end
    end else if (mem_done || !owner_cyc) begin
      busy_q <= 1'b0;
    end
  end

  always_comb begin
    if (!busy_q) begin
      mem_req_o = '0;
    end else if (dbg_own_q) begin
      mem_req_o = dbg_req_i;
    end else begin
      mem_req_o = bus_req_i;
    end
  end

  always_comb begin
    bus_rsp_o.dat = mem_rsp_i.dat;
    bus_rsp_o.ack = mem_rsp_i.ack & busy_q & !dbg_own_q;
    bus_rsp_o.err = mem_rsp_i.err & busy_q & !dbg_own_q;
    dbg_rsp_o.dat = mem_rsp_i.dat;
    dbg_rsp_o.ack = mem_rsp_i.ack & busy_q & dbg_own_q;
    dbg_rsp_o.err = mem_rsp_i.err & busy_q & dbg_own_q;
  end

  a_owner_stable: assert property (@(posedge clk) disable iff (rst_i)
    (mem_req_o.cyc && !mem_done) |=> $stable(dbg_own_q))
    else $error("memory owner changed during an open cycle");

endmodule

/* logic/local_sram.sv */
`timescale 1ns/1ns

module local_sram (
  input  logic              clk,
  input  logic              rst_i,
  input  tile_pkg::wb_req_t req_i,
  output tile_pkg::wb_rsp_t rsp_o
);

  logic [31:0]                mem [0:tile_pkg::LMEM_SIZE/4-1];
  logic [tile_pkg::LMEM_AW-1:0] word_idx;
  logic                       access;
  logic                       ack_q;
  logic [31:0]                dat_q;

  // Upper address bits inside the range alias onto the same words
  assign word_idx = req_i.adr[tile_pkg::LMEM_AW+1:2];
  assign access   = req_i.cyc & req_i.stb & !ack_q;

  always_ff @(posedge clk) begin
    if (access) begin
      dat_q <= mem[word_idx];
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.sel[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;

  a_ack_after_stb: assert property (@(posedge clk) disable iff (rst_i)
    $rose(rsp_o.ack) |-> $past(req_i.cyc && req_i.stb))
    else $error("sram ack without a strobe");

endmodule

/* logic/boot_rom.sv */
`timescale 1ns/1ns

module boot_rom (
  input  logic              clk,
  input  logic              rst_i,
  input  tile_pkg::wb_req_t req_i,
  output tile_pkg::wb_rsp_t rsp_o
);

  logic [9:0]  word_idx;
  logic        access;
  logic        ack_q;
  logic        err_q;
  logic [31:0] dat_q;

  assign word_idx = req_i.adr[11:2];
  assign access   = req_i.cyc & req_i.stb & !ack_q & !err_q;

  // Zero past the end of the image
  always_ff @(posedge clk) begin
    if (word_idx < 10'(tile_pkg::BOOT_WORDS)) begin
      dat_q <= tile_pkg::BOOT_IMAGE[word_idx[3:0]];
    end else begin
      dat_q <= 32'h0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access & !req_i.we;
      err_q <= access & req_i.we;
    end
  end

  assign rsp_o.dat = dat_q;
  assign rsp_o.ack = ack_q;
  assign rsp_o.err = err_q;

endmodule

/* logic/compute_tile_mem.sv */
`timescale 1ns/1ns

module compute_tile_mem (
  input  logic              clk,
  input  logic              rst_i,
  input  tile_pkg::wb_req_t core_ibus_req_i,
  output tile_pkg::wb_rsp_t core_ibus_rsp_o,
  input  tile_pkg::wb_req_t core_dbus_req_i,
  output tile_pkg::wb_rsp_t core_dbus_rsp_o,
  input  tile_pkg::wb_req_t dbg_mem_req_i,
  output tile_pkg::wb_rsp_t dbg_mem_rsp_o
);

  tile_pkg::wb_req_t [tile_pkg::NR_MASTERS-1:0] core_req;
  tile_pkg::wb_rsp_t [tile_pkg::NR_MASTERS-1:0] core_rsp;

  tile_pkg::wb_req_t bus_req;
  tile_pkg::wb_rsp_t bus_rsp;
  tile_pkg::wb_req_t dm_req;
  tile_pkg::wb_rsp_t dm_rsp;
  tile_pkg::wb_req_t boot_req;
  tile_pkg::wb_rsp_t boot_rsp;
  tile_pkg::wb_req_t mem_req;
  tile_pkg::wb_rsp_t mem_rsp;

  assign core_req[0]     = core_ibus_req_i;
  assign core_req[1]     = core_dbus_req_i;
  assign core_ibus_rsp_o = core_rsp[0];
  assign core_dbus_rsp_o = core_rsp[1];

  tile_bus_arbiter u_arbiter (
    .clk       (clk),
    .rst_i     (rst_i),
    .m_req_i   (core_req),
    .m_rsp_o   (core_rsp),
    .bus_req_o (bus_req),
    .bus_rsp_i (bus_rsp)
  );

  tile_addr_decoder u_decoder (
    .clk        (clk),
    .rst_i      (rst_i),
    .bus_req_i  (bus_req),
    .bus_rsp_o  (bus_rsp),
    .dm_req_o   (dm_req),
    .dm_rsp_i   (dm_rsp),
    .boot_req_o (boot_req),
    .boot_rsp_i (boot_rsp)
  );

  // Debug port reaches local memory without crossing the tile bus
  mem_port_mux u_mem_mux (
    .clk       (clk),
    .rst_i     (rst_i),
    .bus_req_i (dm_req),
    .bus_rsp_o (dm_rsp),
    .dbg_req_i (dbg_mem_req_i),
    .dbg_rsp_o (dbg_mem_rsp_o),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  local_sram u_sram (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  boot_rom u_bootrom (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (boot_req),
    .rsp_o (boot_rsp)
  );

endmodule

/* dv/tile_tb_ref.svh */
`ifndef TILE_TB_REF_SVH
`define TILE_TB_REF_SVH

// Byte image of local memory that stays X until written
logic [7:0] ref_mem [0:tile_pkg::LMEM_SIZE-1];

function automatic bit word_known(input logic [31:0] adr);
  int base;
  base = int'({adr[11:2], 2'b00});
  return !$isunknown({ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]});
endfunction

// Local writes also land in the byte image
function automatic tile_pkg::wb_rsp_t expected_response(input tile_pkg::wb_req_t r,
                                                        input bit direct);
  tile_pkg::wb_rsp_t exp;
  logic [3:0]        top;
  int                base;
  exp  = '0;
  top  = r.adr[31:28];
  base = int'({r.adr[11:2], 2'b00});
  if (direct || top == tile_pkg::DM_MATCH) begin
    exp.ack = 1'b1;
    for (int b = 0; b < 4; b++) begin
      if (r.we && r.sel[b]) begin
        ref_mem[base+b] = r.dat[8*b +: 8];
      end
      exp.dat[8*b +: 8] = ref_mem[base+b];
    end
  end else if (top == tile_pkg::BOOT_MATCH) begin
    exp.ack = !r.we;
    exp.err = r.we;
    // Zero beyond the sixteen image words
    if (!r.we && r.adr[11:6] == 6'd0) begin
      exp.dat = tile_pkg::BOOT_IMAGE[r.adr[5:2]];
    end
  end else begin
    exp.err = 1'b1;
  end
  return exp;
endfunction

`endif

/* dv/tile_tb.sv */
`timescale 1ns/1ns

module tile_tb;

  localparam int IBUS              = 0;
  localparam int DBUS              = 1;
  localparam int DBG               = 2;
  localparam int TIMEOUT_CYCLES    = 500;
  localparam int RANDOM_PER_MASTER = 200;

  typedef struct packed {
    logic [1:0]        port;
    tile_pkg::wb_rsp_t got;
    tile_pkg::wb_rsp_t exp;
    logic              chk_dat;
  } result_t;

  logic              clk;
  logic              rst_i;
  tile_pkg::wb_req_t req [0:2];
  tile_pkg::wb_rsp_t rsp [0:2];
  result_t           results [$];
  int                seed;
  int                pass_cnt;
  int                fail_cnt;
  int                test_fail;

  `include "tile_tb_ref.svh"

  compute_tile_mem i_compute_tile_mem (
    .clk             (clk),
    .rst_i           (rst_i),
    .core_ibus_req_i (req[IBUS]),
    .core_ibus_rsp_o (rsp[IBUS]),
    .core_dbus_req_i (req[DBUS]),
    .core_dbus_rsp_o (rsp[DBUS]),
    .dbg_mem_req_i   (req[DBG]),
    .dbg_mem_rsp_o   (rsp[DBG])
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic string port_name(input int port);
    case (port)
      IBUS:    return "core_ibus_rsp_o";
      DBUS:    return "core_dbus_rsp_o";
      default: return "dbg_mem_rsp_o";
    endcase
  endfunction

  // One Wishbone classic access held until ack or err
  task automatic run_access(input int port, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic we);
    tile_pkg::wb_req_t r;
    tile_pkg::wb_rsp_t exp;
    result_t           res;
    int                waited;
    bit                done;
    r     = '0;
    r.adr = adr;
    r.dat = dat;
    r.sel = sel;
    r.we  = we;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    exp   = expected_response(r, port == DBG);
    @(negedge clk);
    req[port] = r;
    waited = 0;
    done   = 0;
    while (!done && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
      done = rsp[port].ack || rsp[port].err;
    end
    if (!done) begin
      $display("%s got no response within %0d cycles for address %h",
               port_name(port), TIMEOUT_CYCLES, adr);
      $display("Regression failed");
      $finish;
    end else begin
      res.port    = 2'(port);
      res.got     = rsp[port];
      res.exp     = exp;
      res.chk_dat = !we && exp.ack;
      results.push_back(res);
      req[port]   = '0;
    end
  endtask

  task automatic check_result(input result_t res);
    string name;
    bit    bad;
    name = port_name(res.port);
    bad  = 0;
    if (res.got.ack !== res.exp.ack) begin
      $display("ERR %0t %s.ack expected %b actual %b", $time, name, res.exp.ack, res.got.ack);
      bad = 1;
    end
    if (res.got.err !== res.exp.err) begin
      $display("ERR %0t %s.err expected %b actual %b", $time, name, res.exp.err, res.got.err);
      bad = 1;
    end
    if (res.chk_dat && res.got.dat !== res.exp.dat) begin
      $display("ERR %0t %s.dat expected %h actual %h", $time, name, res.exp.dat, res.got.dat);
      bad = 1;
    end
    if (bad) begin
      fail_cnt++;
      test_fail++;
    end else begin
      pass_cnt++;
    end
  endtask

  always @(posedge clk) begin
    while (results.size() > 0) begin
      check_result(results.pop_front());
    end
  end

  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (results.size() != 0 && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (results.size() != 0) begin
      $display("Responses of test %s were never compared", name);
      $display("Regression failed");
      $finish;
    end else begin
      $display("Test %s finished with %0d errors", name, test_fail);
      test_fail = 0;
    end
  endtask

  task automatic random_stream(input int port, input int count);
    logic [31:0] a;
    logic [3:0]  s;
    logic        w;
    int          kind;
    for (int k = 0; k < count; k++) begin
      repeat ($unsigned($random(seed)) % 4) @(negedge clk);
      kind = $unsigned($random(seed)) % 8;
      s    = 4'($random(seed));
      w    = 1'($random(seed));
      if (port == DBG || kind < 5) begin
        // Low word index bits name the master
        a = {4'h0, 16'($random(seed)), 8'($random(seed)), 2'(port), 2'b00};
        if (s == 4'h0 || (!w && !word_known(a))) begin
          w = 1'b1;
          s = 4'hf;
        end
      end else if (kind < 7) begin
        a = {tile_pkg::BOOT_MATCH, 16'($random(seed)), 5'h0, 5'($random(seed)), 2'b00};
        w = (kind == 6) && w;
      end else begin
        a = {4'(1 + $unsigned($random(seed)) % 14), 26'($random(seed)), 2'b00};
      end
      run_access(port, a, $random(seed), s, w);
    end
  endtask

  initial begin
    logic [31:0] a;
    seed      = 32'hbc33;
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_fail = 0;
    rst_i     = 1'b1;
    for (int p = 0; p < 3; p++) begin
      req[p] = '0;
    end
    repeat (16) @(negedge clk);
    rst_i = 1'b0;

    for (int c = 0; c < 10; c++) begin
      @(negedge clk);
      for (int p = 0; p < 3; p++) begin
        if (rsp[p].ack !== 1'b0 || rsp[p].err !== 1'b0) begin
          $display("ERR %0t %s ack/err expected 0/0 actual %b/%b",
                   $time, port_name(p), rsp[p].ack, rsp[p].err);
          fail_cnt++;
          test_fail++;
        end else begin
          pass_cnt++;
        end
      end
    end
    finish_test("idle after reset");

    // Full word first so partial writes merge into known bytes
    for (int i = 0; i < 8; i++) begin
      a = 32'h0000_0200 + 32'(4 * i);
      run_access(DBUS, a, $random(seed), 4'hf, 1'b1);
      run_access(DBUS, a, $random(seed), 4'(i + 1), 1'b1);
      run_access(IBUS, a, 32'h0, 4'hf, 1'b0);
      run_access(IBUS, a + (32'(i + 1) << 16), 32'h0, 4'hf, 1'b0);
    end
    finish_test("local memory byte writes");

    for (int i = 0; i < tile_pkg::BOOT_WORDS + 4; i++) begin
      run_access(IBUS, {tile_pkg::BOOT_MATCH, 28'h0} + 32'(4 * i), 32'h0, 4'hf, 1'b0);
    end
    run_access(IBUS, {tile_pkg::BOOT_MATCH, 28'h0000ffc}, 32'h0, 4'hf, 1'b0);
    run_access(IBUS, {tile_pkg::BOOT_MATCH, 28'h1230008}, 32'h0, 4'hf, 1'b0);
    run_access(DBUS, {tile_pkg::BOOT_MATCH, 28'h000000c}, 32'hdeadbeef, 4'hf, 1'b1);
    run_access(IBUS, {tile_pkg::BOOT_MATCH, 28'h000000c}, 32'h0, 4'hf, 1'b0);
    finish_test("boot ROM");

    for (int n = 1; n < 15; n++) begin
      a = {4'(n), 28'($random(seed))} & 32'hffff_fffc;
      run_access(n % 2, a, $random(seed), 4'hf, 1'((n >> 1) & 1));
    end
    finish_test("unmapped addresses");

    for (int i = 0; i < 8; i++) begin
      a = 32'h0000_0400 + 32'(4 * i);
      run_access(DBG, a, $random(seed), 4'hf, 1'b1);
      run_access(DBUS, a, 32'h0, 4'hf, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      a = 32'h0000_0480 + 32'(4 * i);
      run_access(DBUS, a, $random(seed), 4'hf, 1'b1);
      run_access(DBG, a, 32'h0, 4'hf, 1'b0);
    end
    finish_test("debug and data port sharing");

    fork
      random_stream(IBUS, RANDOM_PER_MASTER);
      random_stream(DBUS, RANDOM_PER_MASTER);
      random_stream(DBG, RANDOM_PER_MASTER);
    join
    finish_test("random traffic from all masters");

    $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* compute_tile_mem.f */
+incdir+dv
logic/tile_pkg.sv
logic/tile_bus_arbiter.sv
logic/tile_addr_decoder.sv
logic/mem_port_mux.sv
logic/local_sram.sv
logic/boot_rom.sv
logic/compute_tile_mem.sv
dv/tile_tb.sv
